// ==== filelist.f ====
source/archie_pkg.sv
source/clk_enable_gen.sv
source/vidc_pll_reconfig.sv
source/loader_port.sv
source/mem_arbiter.sv
source/archie_support_top.sv
bench/tb_archie_support.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tb_archie_support --Mdir obj_dir

./obj_dir/Vtb_archie_support | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
	echo "no result in sim.log"
	exit 1
fi
echo "simulation passed"

// ==== bench/tb_archie_support.sv ====
`timescale 1ns/1ps

module tb_archie_support import archie_pkg::*; ();

	localparam int CLKEN_PERIOD     = 20;
	localparam int RECONFIG_TIMEOUT = 16;
	localparam int LOAD_WRITES      = 12;
	// reset, enables, load, core phases and three retunes
	localparam int RUN_CYCLES = 8 + 10 * CLKEN_PERIOD + LOAD_WRITES * 12 + 120
	                          + 3 * (8 * RECONFIG_TIMEOUT + 40);

	logic         clk_sys = 1'b0;
	logic         rst_i, clk2m_en_o, clk8m_en_o;
	logic         downloading_i, ioctl_wr_i, rom_ready_o;
	dio_index_t   dio_index_i;
	loader_addr_t ioctl_addr_i;
	byte_t        ioctl_dout_i;
	logic         core_stb_i, core_we_i, core_ack_o, core_reset_o, ram_ready_i, reset_button_i;
	sel_t         core_sel_i, mem_sel_o;
	core_addr_t   core_adr_i;
	word_t        core_dat_i, mem_dat_o;
	logic         mem_stb_o, mem_cyc_o, mem_we_o, mem_ack_i;
	bus_addr_t    mem_adr_o;
	pixclk_sel_t  pixclk_sel_i;
	logic         busy_i, rom_q_24_i, rom_q_25_i, rom_q_36_i, rom_q_o;
	logic         write_from_rom_o, reconfig_o, reconfig_reset_o, vidc_clk_ena_o;

	integer seed = 32'he48e9a4c;
	int     value_errs = 0; // wrong values on outputs
	int     proto_errs = 0; // missing acks, stuck sequencer
	int     busy_hold = 4;  // cycles the pll engine reports busy

	archie_support_top #(
		.CLKEN_PERIOD     (CLKEN_PERIOD),
		.RECONFIG_TIMEOUT (RECONFIG_TIMEOUT)
	) u_archie_support_top (.*);

	always #5 clk_sys = ~clk_sys;

	// memory acks 1 to 4 cycles after a request shows up
	initial begin
		int ack_delay;
		mem_ack_i <= 1'b0;
		forever begin
			@(negedge clk_sys);
			if (mem_stb_o && mem_cyc_o) begin
				ack_delay = 1 + int'({$random(seed)} % 32'd4);
				repeat (ack_delay) @(posedge clk_sys);
				mem_ack_i <= 1'b1;
				@(posedge clk_sys);
				mem_ack_i <= 1'b0;
			end
		end
	end

	// pll engine goes busy right after each reconfig pulse
	initial begin
		busy_i <= 1'b0;
		forever begin
			@(negedge clk_sys);
			if (reconfig_o) begin
				@(posedge clk_sys);
				busy_i <= 1'b1;
				repeat (busy_hold) @(posedge clk_sys);
				busy_i <= 1'b0;
			end
		end
	end

	initial begin
		repeat (2 * RUN_CYCLES) @(posedge clk_sys);
		$display("watchdog expired after %0d cycles, the run did not complete", 2 * RUN_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	task automatic count_clock_enables;
		int n2m;
		int n8m;
		int last8m;
		begin
			n2m    = 0;
			n8m    = 0;
			last8m = -1;
			for (int c = 0; c < 10 * CLKEN_PERIOD; c++) begin
				@(negedge clk_sys);
				if (clk8m_en_o) begin
					if (last8m >= 0 && c - last8m != CLKEN_PERIOD / 4) begin
						value_errs++;
						$display("Fail at %0t: 8 MHz enable gap %0d", $time, c - last8m);
					end
					last8m = c;
					n8m++;
				end
				if (clk2m_en_o) begin
					n2m++;
					if (!clk8m_en_o) begin
						value_errs++;
						$display("Fail at %0t: 2 MHz enable without 8 MHz enable", $time);
					end
				end
			end
			if (n2m != 10 || n8m != 40) begin
				value_errs++;
				$display("Fail at %0t: enable counts %0d and %0d, expected 10 and 40",
				         $time, n2m, n8m);
			end
		end
	endtask

	// one download write, then follow its bus request up to the ack
	task automatic write_loader_byte(input loader_addr_t addr, input byte_t data);
		sel_t      exp_sel;
		bus_addr_t exp_adr;
		int        waited;
		bit        done;
		begin
			exp_sel = sel_t'(4'b0001 << addr[1:0]);
			exp_adr = bus_addr_t'(addr & ~24'h3);
			waited  = 0;
			done    = 0;
			@(posedge clk_sys);
			ioctl_wr_i   <= 1'b1;
			ioctl_addr_i <= addr;
			ioctl_dout_i <= data;
			@(posedge clk_sys);
			ioctl_wr_i <= 1'b0;
			while (!done) begin
				@(negedge clk_sys);
				if (!mem_stb_o || !mem_cyc_o || !mem_we_o || mem_sel_o !== exp_sel ||
				    mem_adr_o !== exp_adr || mem_dat_o !== {4{data}} || core_ack_o ||
				    !core_reset_o) begin
					value_errs++;
					$display("Fail at %0t: stb %b we %b sel %h adr %h dat %h, want sel %h adr %h",
					         $time, mem_stb_o, mem_we_o, mem_sel_o, mem_adr_o, mem_dat_o,
					         exp_sel, exp_adr);
				end
				if (mem_ack_i) begin
					done = 1;
				end else if (waited == 8) begin
					proto_errs++;
					$display("memory never acked the loader write to %h", addr);
					done = 1;
				end
				waited++;
			end
			@(negedge clk_sys);
			if (mem_stb_o) begin
				value_errs++;
				$display("Fail at %0t: loader strobe still high after ack", $time);
			end
		end
	endtask

	task automatic load_rom_image;
		begin
			@(posedge clk_sys);
			dio_index_i   <= LOADER_IDX_OS;
			downloading_i <= 1'b1;
			repeat (LOAD_WRITES / 2)
				write_loader_byte(loader_addr_t'($random(seed)), byte_t'($random(seed)));
			@(posedge clk_sys);
			dio_index_i <= 8'd2; // aux image lands in memory too
			repeat (LOAD_WRITES / 2)
				write_loader_byte(loader_addr_t'($random(seed)), byte_t'($random(seed)));
			@(posedge clk_sys);
			downloading_i <= 1'b0;
			@(negedge clk_sys);
			if (rom_ready_o) begin
				value_errs++;
				$display("Fail at %0t: rom_ready_o rose with the loader still active", $time);
			end
			@(negedge clk_sys);
			if (!rom_ready_o) begin
				value_errs++;
				$display("Fail at %0t: rom_ready_o low after the download ended", $time);
			end
		end
	endtask

	task automatic core_access(input logic we, input sel_t sel, input core_addr_t adr,
	                           input word_t dat);
		logic [26:0] byte_adr;
		bus_addr_t   exp_adr;
		int          waited;
		bit          done;
		begin
			byte_adr = {adr, 2'b00};
			exp_adr  = {2'b00, byte_adr[23:0]}; // only 16 MB reach memory
			waited   = 0;
			done     = 0;
			@(posedge clk_sys);
			core_stb_i <= 1'b1;
			core_we_i  <= we;
			core_sel_i <= sel;
			core_adr_i <= adr;
			core_dat_i <= dat;
			while (!done) begin
				@(negedge clk_sys);
				if (!mem_stb_o || !mem_cyc_o || mem_we_o !== we || mem_sel_o !== sel ||
				    mem_adr_o !== exp_adr || mem_dat_o !== dat || core_ack_o !== mem_ack_i) begin
					value_errs++;
					$display("Fail at %0t: core request adr %h dat %h ack %b, want adr %h dat %h",
					         $time, mem_adr_o, mem_dat_o, core_ack_o, exp_adr, dat);
				end
				done = mem_ack_i || waited == 8;
				if (!mem_ack_i && waited == 8) begin
					proto_errs++;
					$display("memory never acked the core request to %h", adr);
				end
				waited++;
			end
			@(posedge clk_sys);
			core_stb_i <= 1'b0;
		end
	endtask

	task automatic ignore_other_index;
		begin
			@(posedge clk_sys);
			dio_index_i   <= 8'd3;
			downloading_i <= 1'b1;
			repeat (3) begin
				@(posedge clk_sys);
				ioctl_wr_i   <= 1'b1;
				ioctl_addr_i <= loader_addr_t'($random(seed));
				@(posedge clk_sys);
				ioctl_wr_i <= 1'b0;
				repeat (3) begin
					@(negedge clk_sys);
					if (mem_stb_o || mem_cyc_o) begin
						value_errs++;
						$display("Fail at %0t: memory strobe for download index 3", $time);
					end
				end
			end
			core_access(1'b1, 4'b1100, core_addr_t'($random(seed)), word_t'($random(seed)));
			@(posedge clk_sys);
			downloading_i <= 1'b0;
		end
	endtask

	task automatic step_core_reset(input logic ram_ready, input logic button, input logic exp);
		begin
			@(posedge clk_sys);
			ram_ready_i    <= ram_ready;
			reset_button_i <= button;
			@(negedge clk_sys);
			if (core_reset_o !== exp) begin
				value_errs++;
				$display("Fail at %0t: core_reset_o %b, expected %b", $time, core_reset_o, exp);
			end
		end
	endtask

	// changes the pixel clock and counts the sequencer pulses until the clocks run again
	task automatic pll_change(input pixclk_sel_t new_sel, input int hold, input bit stuck);
		int wr_cnt;
		int rc_cnt;
		int rst_cnt;
		int since_rc;
		int cycles;
		bit gated;
		bit done;
		begin
			wr_cnt    = 0;
			rc_cnt    = 0;
			rst_cnt   = 0;
			since_rc  = 0;
			cycles    = 0;
			gated     = 0;
			done      = 0;
			busy_hold = hold;
			@(posedge clk_sys);
			pixclk_sel_i <= new_sel;
			while (!done) begin
				@(negedge clk_sys);
				cycles++;
				since_rc++;
				wr_cnt += int'(write_from_rom_o);
				if (reconfig_o) begin
					rc_cnt++;
					since_rc = 0;
				end
				if (reconfig_reset_o) begin
					rst_cnt++;
					if (since_rc > RECONFIG_TIMEOUT + 2) begin
						value_errs++;
						$display("Fail at %0t: engine reset %0d cycles late", $time, since_rc);
					end
				end
				if (!vidc_clk_ena_o)
					gated = 1;
				else if (gated)
					done = 1;
				if (cycles > 8 * RECONFIG_TIMEOUT + 40) begin
					proto_errs++;
					$display("pll sequencer never restarted the pixel clocks");
					done = 1;
				end
			end
			if (wr_cnt != 1 || rc_cnt != 1 || rst_cnt != (stuck ? 1 : 0)) begin
				value_errs++;
				$display("Fail at %0t: rom write %0d, reconfig %0d, engine reset %0d pulses",
				         $time, wr_cnt, rc_cnt, rst_cnt);
			end
			for (int i = 0; i < 8; i++) begin // walk all rom bit patterns
				@(posedge clk_sys);
				rom_q_24_i <= i[0];
				rom_q_25_i <= i[1];
				rom_q_36_i <= i[2];
				@(negedge clk_sys);
				if (rom_q_o !== (new_sel == 2'b01 ? i[1] : new_sel == 2'b10 ? i[2] : i[0])) begin
					value_errs++;
					$display("Fail at %0t: rom_q_o %b for roms %b, select %b",
					         $time, rom_q_o, i[2:0], new_sel);
				end
			end
			while (busy_i)
				@(negedge clk_sys);
		end
	endtask

	initial begin
		rst_i          <= 1'b1;
		downloading_i  <= 1'b0;
		dio_index_i    <= '0;
		ioctl_wr_i     <= 1'b0;
		ioctl_addr_i   <= '0;
		ioctl_dout_i   <= '0;
		core_stb_i     <= 1'b0;
		core_we_i      <= 1'b0;
		core_sel_i     <= '0;
		core_adr_i     <= '0;
		core_dat_i     <= '0;
		ram_ready_i    <= 1'b0;
		reset_button_i <= 1'b0;
		pixclk_sel_i   <= PIXCLK_RESET_SEL; // no retune right out of reset
		rom_q_24_i     <= 1'b0;
		rom_q_25_i     <= 1'b0;
		rom_q_36_i     <= 1'b0;
		repeat (8) @(posedge clk_sys);
		rst_i <= 1'b0;
		count_clock_enables();
		step_core_reset(1'b0, 1'b0, 1'b1);
		step_core_reset(1'b1, 1'b0, 1'b1); // ram up but no rom image yet
		load_rom_image();
		ignore_other_index();
		step_core_reset(1'b0, 1'b0, 1'b1);
		step_core_reset(1'b1, 1'b0, 1'b0);
		step_core_reset(1'b1, 1'b1, 1'b1);
		step_core_reset(1'b1, 1'b0, 1'b0);
		core_access(1'b1, 4'b0110, core_addr_t'($random(seed)), word_t'($random(seed)));
		core_access(1'b0, 4'b1111, core_addr_t'($random(seed)), word_t'($random(seed)));
		pll_change(2'b01, 5, 1'b0);
		pll_change(2'b00, 9, 1'b0);
		pll_change(2'b10, 4 * RECONFIG_TIMEOUT, 1'b1); // engine stays busy into the timeout
		$display("value errors %0d, protocol errors %0d", value_errs, proto_errs);
		if (value_errs == 0 && proto_errs == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== source/archie_support_top.sv ====
`timescale 1ns/1ps

module archie_support_top import archie_pkg::*; #(
	parameter int CLKEN_PERIOD     = 20,
	parameter int RECONFIG_TIMEOUT = 1000
) (
	input  logic         clk_sys,
	input  logic         rst_i,
	// clock enables for the core
	output logic         clk2m_en_o,
	output logic         clk8m_en_o,
	// download port
	input  logic         downloading_i,
	input  dio_index_t   dio_index_i,
	input  logic         ioctl_wr_i,
	input  loader_addr_t ioctl_addr_i,
	input  byte_t        ioctl_dout_i,
	output logic         rom_ready_o,
	// core memory master
	input  logic         core_stb_i,
	input  logic         core_we_i,
	input  sel_t         core_sel_i,
	input  core_addr_t   core_adr_i,
	input  word_t        core_dat_i,
	output logic         core_ack_o,
	output logic         core_reset_o,
	input  logic         ram_ready_i,
	input  logic         reset_button_i,
	// memory bus
	output logic         mem_stb_o,
	output logic         mem_cyc_o,
	output logic         mem_we_o,
	output sel_t         mem_sel_o,
	output bus_addr_t    mem_adr_o,
	output word_t        mem_dat_o,
	input  logic         mem_ack_i,
	// video PLL reconfig engine
	input  pixclk_sel_t  pixclk_sel_i,
	input  logic         busy_i,
	input  logic         rom_q_24_i,
	input  logic         rom_q_25_i,
	input  logic         rom_q_36_i,
	output logic         rom_q_o,
	output logic         write_from_rom_o,
	output logic         reconfig_o,
	output logic         reconfig_reset_o,
	output logic         vidc_clk_ena_o
);

	logic      loader_active;
	logic      loader_stb;
	sel_t      loader_sel;
	bus_addr_t loader_addr;
	word_t     loader_data;
	logic      loader_ack;

	clk_enable_gen #(
		.CLKEN_PERIOD (CLKEN_PERIOD)
	) u_clk_enable_gen (
		.clk_sys    (clk_sys),
		.rst_i      (rst_i),
		.clk2m_en_o (clk2m_en_o),
		.clk8m_en_o (clk8m_en_o)
	);

	vidc_pll_reconfig #(
		.RECONFIG_TIMEOUT (RECONFIG_TIMEOUT)
	) u_vidc_pll_reconfig (
		.clk_sys          (clk_sys),
		.rst_i            (rst_i),
		.pixclk_sel_i     (pixclk_sel_i),
		.busy_i           (busy_i),
		.rom_q_24_i       (rom_q_24_i),
		.rom_q_25_i       (rom_q_25_i),
		.rom_q_36_i       (rom_q_36_i),
		.rom_q_o          (rom_q_o),
		.write_from_rom_o (write_from_rom_o),
		.reconfig_o       (reconfig_o),
		.reconfig_reset_o (reconfig_reset_o),
		.vidc_clk_ena_o   (vidc_clk_ena_o)
	);

	loader_port u_loader_port (
		.clk_sys         (clk_sys),
		.rst_i           (rst_i),
		.downloading_i   (downloading_i),
		.dio_index_i     (dio_index_i),
		.ioctl_wr_i      (ioctl_wr_i),
		.ioctl_addr_i    (ioctl_addr_i),
		.ioctl_dout_i    (ioctl_dout_i),
		.loader_ack_i    (loader_ack),
		.loader_active_o (loader_active),
		.loader_stb_o    (loader_stb),
		.loader_sel_o    (loader_sel),
		.loader_addr_o   (loader_addr),
		.loader_data_o   (loader_data),
		.rom_ready_o     (rom_ready_o)
	);

	mem_arbiter u_mem_arbiter (
		.loader_active_i (loader_active),
		.loader_stb_i    (loader_stb),
		.loader_sel_i    (loader_sel),
		.loader_addr_i   (loader_addr),
		.loader_data_i   (loader_data),
		.rom_ready_i     (rom_ready_o),
		.core_stb_i      (core_stb_i),
		.core_we_i       (core_we_i),
		.core_sel_i      (core_sel_i),
		.core_adr_i      (core_adr_i),
		.core_dat_i      (core_dat_i),
		.mem_ack_i       (mem_ack_i),
		.ram_ready_i     (ram_ready_i),
		.reset_button_i  (reset_button_i),
		.rst_i           (rst_i),
		.mem_stb_o       (mem_stb_o),
		.mem_cyc_o       (mem_cyc_o),
		.mem_we_o        (mem_we_o),
		.mem_sel_o       (mem_sel_o),
		.mem_adr_o       (mem_adr_o),
		.mem_dat_o       (mem_dat_o),
		.loader_ack_o    (loader_ack),
		.core_ack_o      (core_ack_o),
		.core_reset_o    (core_reset_o)
	);

endmodule

// ==== source/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter import archie_pkg::*; (
	input  logic       loader_active_i,
	input  logic       loader_stb_i,
	input  sel_t       loader_sel_i,
	input  bus_addr_t  loader_addr_i,
	input  word_t      loader_data_i,
	input  logic       rom_ready_i,
	input  logic       core_stb_i,
	input  logic       core_we_i,
	input  sel_t       core_sel_i,
	input  core_addr_t core_adr_i,
	input  word_t      core_dat_i,
	input  logic       mem_ack_i,
	input  logic       ram_ready_i,
	input  logic       reset_button_i,
	input  logic       rst_i,
	output logic       mem_stb_o,
	output logic       mem_cyc_o,
	output logic       mem_we_o,
	output sel_t       mem_sel_o,
	output bus_addr_t  mem_adr_o,
	output word_t      mem_dat_o,
	output logic       loader_ack_o,
	output logic       core_ack_o,
	output logic       core_reset_o
);

	bus_addr_t core_bus_adr;

	// core index 0 is address bit 2, keep byte address bits 23..2
	assign core_bus_adr = {2'b00, core_adr_i[21:0], 2'b00};

	always_comb begin
		if (loader_active_i) begin
			mem_stb_o = loader_stb_i;
			mem_cyc_o = loader_stb_i;
			mem_we_o  = 1'b1;       // loader only writes
			mem_sel_o = loader_sel_i;
			mem_adr_o = loader_addr_i;
			mem_dat_o = loader_data_i;
		end else begin
			mem_stb_o = core_stb_i;
			mem_cyc_o = core_stb_i; // cyc follows stb on the core side
			mem_we_o  = core_we_i;
			mem_sel_o = core_sel_i;
			mem_adr_o = core_bus_adr;
			mem_dat_o = core_dat_i;
		end
	end

	// ack goes back to whoever owns the bus
	assign loader_ack_o = loader_active_i & mem_ack_i;
	assign core_ack_o   = ~loader_active_i & mem_ack_i;

	// core held in reset until memory and rom image are both there
	assign core_reset_o = rst_i | ~ram_ready_i | ~rom_ready_i | reset_button_i;

endmodule

// ==== source/loader_port.sv ====
`timescale 1ns/1ps

module loader_port import archie_pkg::*; (
	input  logic         clk_sys,
	input  logic         rst_i,
	input  logic         downloading_i,
	input  dio_index_t   dio_index_i,
	input  logic         ioctl_wr_i,
	input  loader_addr_t ioctl_addr_i,
	input  byte_t        ioctl_dout_i,
	input  logic         loader_ack_i,
	output logic         loader_active_o,
	output logic         loader_stb_o,
	output sel_t         loader_sel_o,
	output bus_addr_t    loader_addr_o,
	output word_t        loader_data_o,
	output logic         rom_ready_o
);

	logic         active_d;
	loader_addr_t wr_addr;  // captured with the write
	byte_t        wr_byte;

	// only OS and aux images go to memory
	assign loader_active_o = downloading_i &&
	                         (dio_index_i == LOADER_IDX_OS || dio_index_i == LOADER_IDX_AUX);

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			loader_stb_o <= 1'b0;
			active_d     <= 1'b0;
			rom_ready_o  <= 1'b0;
		end else begin
			active_d <= loader_active_o;
			if (active_d && !loader_active_o)
				rom_ready_o <= 1'b1; // sticky until reset
			if (ioctl_wr_i && loader_active_o)
				loader_stb_o <= 1'b1;
			else if (loader_ack_i)
				loader_stb_o <= 1'b0;
		end
	end

	// payload held for the whole request
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr_i && loader_active_o) begin
			wr_addr <= ioctl_addr_i;
			wr_byte <= ioctl_dout_i;
		end
	end

	// one lane per byte offset
	always_comb begin
		case (wr_addr[1:0])
			2'b00:   loader_sel_o = 4'b0001;
			2'b01:   loader_sel_o = 4'b0010;
			2'b10:   loader_sel_o = 4'b0100;
			default: loader_sel_o = 4'b1000;
		endcase
	end

	assign loader_addr_o = {2'b00, wr_addr[23:2], 2'b00};
	assign loader_data_o = {4{wr_byte}}; // memory picks the lane by sel

endmodule

// ==== source/vidc_pll_reconfig.sv ====
`timescale 1ns/1ps

module vidc_pll_reconfig import archie_pkg::*; #(
	parameter int RECONFIG_TIMEOUT = 1000
) (
	input  logic        clk_sys,
	input  logic        rst_i,
	input  pixclk_sel_t pixclk_sel_i,
	input  logic        busy_i,
	input  logic        rom_q_24_i,
	input  logic        rom_q_25_i,
	input  logic        rom_q_36_i,
	output logic        rom_q_o,
	output logic        write_from_rom_o,
	output logic        reconfig_o,
	output logic        reconfig_reset_o,
	output logic        vidc_clk_ena_o
);

	reconfig_state_t state;
	pixclk_sel_t     sel_d;   // select the PLL is currently set up for
	logic [9:0]      timer;

	// settings stream comes from the ROM matching the requested clock
	always_comb begin
		case (pixclk_sel_i)
			2'b01:   rom_q_o = rom_q_25_i;
			2'b10:   rom_q_o = rom_q_36_i;
			default: rom_q_o = rom_q_24_i;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			state            <= RC_IDLE;
			sel_d            <= PIXCLK_RESET_SEL;
			timer            <= '0;
			vidc_clk_ena_o   <= 1'b0;
			write_from_rom_o <= 1'b0;
			reconfig_o       <= 1'b0;
			reconfig_reset_o <= 1'b0;
		end else begin
			// pulses by default
			write_from_rom_o <= 1'b0;
			reconfig_o       <= 1'b0;
			reconfig_reset_o <= 1'b0;

			case (state)
				RC_IDLE: begin
					vidc_clk_ena_o <= 1'b1;
					sel_d          <= pixclk_sel_i;
					if (sel_d != pixclk_sel_i) begin
						vidc_clk_ena_o   <= 1'b0; // stop pixel clocks while retuning
						write_from_rom_o <= 1'b1;
						state            <= RC_PREP;
					end
				end
				RC_PREP: state <= RC_WAIT; // engine needs a cycle to latch the rom write
				RC_WAIT: begin
					if (!busy_i) begin
						reconfig_o <= 1'b1;
						timer      <= 10'(RECONFIG_TIMEOUT);
						state      <= RC_RUN;
					end
				end
				RC_RUN: begin
					timer <= timer - 1'b1;
					if (timer == 10'd1) begin
						// engine stuck busy, kick it
						reconfig_reset_o <= 1'b1;
						state            <= RC_IDLE;
					end
					if (!reconfig_o && !busy_i)
						state <= RC_IDLE;
				end
				default: state <= RC_IDLE;
			endcase
		end
	end

endmodule

// ==== source/clk_enable_gen.sv ====
`timescale 1ns/1ps

module clk_enable_gen #(
	parameter int CLKEN_PERIOD = 20
) (
	input  logic clk_sys,
	input  logic rst_i,
	output logic clk2m_en_o,
	output logic clk8m_en_o
);

	localparam int CNT_W   = $clog2(CLKEN_PERIOD);
	localparam int QUARTER = CLKEN_PERIOD / 4;

	logic [CNT_W-1:0] clken_cnt;
	logic             cnt_wrap;
	logic             quarter_hit;

	assign cnt_wrap = (clken_cnt == CNT_W'(CLKEN_PERIOD - 1));

	// four evenly spaced phases per period
	assign quarter_hit = (clken_cnt == CNT_W'(0))           ||
	                     (clken_cnt == CNT_W'(QUARTER))     ||
	                     (clken_cnt == CNT_W'(2 * QUARTER)) ||
	                     (clken_cnt == CNT_W'(3 * QUARTER));

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			clken_cnt  <= '0;
			clk2m_en_o <= 1'b0;
			clk8m_en_o <= 1'b0;
		end else begin
			clken_cnt  <= cnt_wrap ? '0 : clken_cnt + 1'b1;
			clk2m_en_o <= (clken_cnt == CNT_W'(0)); // slow phase only
			clk8m_en_o <= quarter_hit;
		end
	end

endmodule

// ==== source/archie_pkg.sv ====
package archie_pkg;

	// memory bus
	typedef logic [31:0] word_t;
	typedef logic [3:0]  sel_t;
	typedef logic [25:0] bus_addr_t;

	// core side address, core bits 26 down to 2
	typedef logic [24:0] core_addr_t;

	// download side
	typedef logic [7:0]  byte_t;
	typedef logic [23:0] loader_addr_t;
	typedef logic [7:0]  dio_index_t;

	// pixel base clock: 01 = 25 MHz, 10 = 36 MHz, anything else = 24 MHz
	typedef logic [1:0]  pixclk_sel_t;

	typedef enum logic [1:0] {
		RC_IDLE = 2'b00,
		RC_PREP = 2'b01,
		RC_WAIT = 2'b10,
		RC_RUN  = 2'b11
	} reconfig_state_t;

	// image indices that land in system memory
	localparam dio_index_t LOADER_IDX_OS  = 8'd1;
	localparam dio_index_t LOADER_IDX_AUX = 8'd2;

	// the PLL comes up in the 36 MHz setting
	localparam pixclk_sel_t PIXCLK_RESET_SEL = 2'b10;

endpackage
